/* all.f */
logic/routerPkg.sv
logic/flitFifo.sv
logic/packetTimer.sv
logic/switchArbiter.sv
logic/linkSender.sv
logic/routerOutputPort.sv
verif/routerOutputPort_assertions.sv
verif/routerTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = routerTb
FILELIST = all.f
LOG      = sim.log

.PHONY: sim lint clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* verif/packetStimulus.txt */
// test line: id, outReady mode (0 high, 1 low until loaded, 2 xorshift), packet count,
// order count, inReady expected once loaded; packet line: port (0 L .. 4 S), length, tag, start
// order line: packet numbers in the order their flits leave the output, id 0 ends the list
2 0 1 1 1f
2 4 a2 0
0
// two packets per port queued behind a stalled output
3 1 a a 1f
0 2 310 0
1 2 311 0
2 2 312 0
3 2 313 0
4 2 314 0
0 2 320 0
1 2 321 0
2 2 322 0
3 2 323 0
4 2 324 0
0 1 2 3 4 5 6 7 8 9
// same load with random stalls on the output
4 2 a a 1f
0 2 310 0
1 2 311 0
2 2 312 0
3 2 313 0
4 2 314 0
0 2 320 0
1 2 321 0
2 2 322 0
3 2 323 0
4 2 324 0
0 1 2 3 4 5 6 7 8 9
// ten flits fill the N FIFO plus the two skid entries
5 1 1 1 1d
1 a 550 0
0
// W starts while E holds the output
6 0 2 2 1f
2 6 660 0
3 3 630 3
0 1
0

/* verif/routerTb.sv */
`default_nettype none

module routerTb;
  timeunit 1ns;
  timeprecision 100ps;

  logic clk;
  logic rst;
  logic [routerPkg::numPorts-1:0] inValid;
  routerPkg::flitWord inFlit [routerPkg::numPorts];
  logic [routerPkg::numPorts-1:0] inReady;
  logic outValid;
  routerPkg::flitWord outFlit;
  logic outReady;

  logic [31:0] stim [256];
  routerPkg::flitWord portFlits [routerPkg::numPorts][64];
  int portStart [routerPkg::numPorts][64];
  int portCount [routerPkg::numPorts];
  int portPos [routerPkg::numPorts];
  routerPkg::flitWord expectFlits [256];
  int expectCount;
  int errors;
  int passCount;
  int failCount;
  int timeoutLimit;
  logic [31:0] rngState;

  routerOutputPort i_routerOutputPort
  (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inFlit(inFlit),
    .inReady(inReady),
    .outValid(outValid),
    .outFlit(outFlit),
    .outReady(outReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    wait (timeoutLimit != 0);
    while (cycles < timeoutLimit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with output flits still missing", cycles);
    $display("TEST FAIL");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // flit k of a packet carries its tag in the header srcInfo and in the body payload
  function automatic routerPkg::flitWord makeFlit(input int tag, input int length, input int k);
    routerPkg::flitWord f;
    int payload;
    payload = (tag << 8) | k;
    f = '0;
    if (k == 0)
    begin
      f.header.flitId = routerPkg::flitIdHeader;
      f.header.length = length[11:0];
      f.header.srcInfo = tag[16:0];
    end
    else
    begin
      f.body.flitId = routerPkg::flitIdBody;
      f.body.payload = payload[28:0];
    end
    return f;
  endfunction

  task automatic compareFlit(input string name, input routerPkg::flitWord expected,
                             input routerPkg::flitWord actual);
    if (actual !== expected)
    begin
      $display("** Error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic verifyPorts(input string name, input logic [routerPkg::numPorts-1:0] expected,
                             input logic [routerPkg::numPorts-1:0] actual);
    if (actual !== expected)
    begin
      $display("** Error at %0t ns: %s expected %b got %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic inspectBit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("** Error at %0t ns: %s expected %b got %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic reportTest(input int id, input int errorsBefore);
    if (errors == errorsBefore)
    begin
      $display("test %0d passed", id);
      passCount++;
    end
    else
    begin
      $display("test %0d failed with %0d errors", id, errors - errorsBefore);
      failCount++;
    end
  endtask

  // fills the per-port flit lists and the expected output sequence of one test
  task automatic loadTest(input int base);
    int numPackets;
    int pkt;
    int port;
    int length;
    int tag;
    int k;
    numPackets = int'(stim[base + 2]);
    expectCount = 0;
    for (port = 0; port < routerPkg::numPorts; port++)
    begin
      portCount[port] = 0;
      portPos[port] = 0;
    end
    for (pkt = 0; pkt < numPackets; pkt++)
    begin
      port = int'(stim[base + 5 + 4 * pkt]);
      length = int'(stim[base + 6 + 4 * pkt]);
      tag = int'(stim[base + 7 + 4 * pkt]);
      for (k = 0; k < length; k++)
      begin
        portFlits[port][portCount[port]] = makeFlit(tag, length, k);
        portStart[port][portCount[port]] = int'(stim[base + 8 + 4 * pkt]);
        portCount[port]++;
      end
    end
    for (int idx = 0; idx < int'(stim[base + 3]); idx++)
    begin
      pkt = int'(stim[base + 5 + 4 * numPackets + idx]);
      length = int'(stim[base + 6 + 4 * pkt]);
      tag = int'(stim[base + 7 + 4 * pkt]);
      for (k = 0; k < length; k++)
      begin
        expectFlits[expectCount] = makeFlit(tag, length, k);
        expectCount++;
      end
    end
  endtask

  task automatic runTest(input int base);
    int mode;
    int testCycle;
    int received;
    int holdCycles;
    int idleCycles;
    int errorsBefore;
    logic loaded;
    mode = int'(stim[base + 1]);
    errorsBefore = errors;
    loadTest(base);
    testCycle = 0;
    received = 0;
    holdCycles = 0;
    idleCycles = 0;
    // after the last expected flit the output must stay quiet for ten cycles
    while (received < expectCount || idleCycles < 10)
    begin
      @(posedge clk);
      loaded = 1'b1;
      for (int port = 0; port < routerPkg::numPorts; port++)
      begin
        if (inValid[port] && inReady[port])
          portPos[port]++;
        if (portPos[port] < portCount[port])
          loaded = 1'b0;
      end
      if (received >= expectCount)
      begin
        inspectBit("outValid", 1'b0, outValid);
        idleCycles++;
      end
      else if (outValid && outReady)
      begin
        compareFlit("outFlit", expectFlits[received], outFlit);
        received++;
      end
      for (int port = 0; port < routerPkg::numPorts; port++)
      begin
        if (portPos[port] < portCount[port] && testCycle >= portStart[port][portPos[port]])
        begin
          inValid[port] <= 1'b1;
          inFlit[port] <= portFlits[port][portPos[port]];
        end
        else
          inValid[port] <= 1'b0;
      end
      if (mode == 0)
        outReady <= 1'b1;
      else if (mode == 2)
      begin
        rngState = xorshift(rngState);
        outReady <= rngState[4];
      end
      else if (!loaded || holdCycles < 4)
      begin
        if (loaded)
          holdCycles++;
        outReady <= 1'b0;
      end
      else
      begin
        // the stalled load has settled, so the ready vector shows which FIFOs are full
        if (holdCycles == 4)
        begin
          verifyPorts("inReady", stim[base + 4][routerPkg::numPorts-1:0], inReady);
          holdCycles++;
        end
        outReady <= 1'b1;
      end
      testCycle++;
    end
    reportTest(int'(stim[base]), errorsBefore);
  endtask

  initial
  begin
    int rd;
    int totalFlits;
    rst = 1'b1;
    inValid = '0;
    outReady = 1'b0;
    for (int port = 0; port < routerPkg::numPorts; port++)
      inFlit[port] = '0;
    errors = 0;
    passCount = 0;
    failCount = 0;
    timeoutLimit = 0;
    rngState = 32'd86;
    $readmemh("verif/packetStimulus.txt", stim);
    rd = 0;
    totalFlits = 0;
    while (stim[rd] != 0)
    begin
      for (int pkt = 0; pkt < int'(stim[rd + 2]); pkt++)
        totalFlits += int'(stim[rd + 6 + 4 * pkt]);
      rd += 5 + 4 * int'(stim[rd + 2]) + int'(stim[rd + 3]);
    end
    timeoutLimit = 8 * totalFlits + 200;

    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    inspectBit("outValid", 1'b0, outValid);
    verifyPorts("inReady", '1, inReady);
    reportTest(1, 0);

    rd = 0;
    while (stim[rd] != 0)
    begin
      runTest(rd);
      rd += 5 + 4 * int'(stim[rd + 2]) + int'(stim[rd + 3]);
    end

    $display("tests passed %0d failed %0d errors %0d", passCount, failCount, errors);
    if (failCount == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/routerOutputPort_assertions.sv */
`default_nettype none

module arbiterProtocolChecks
(
  input logic                           clk,
  input logic                           rst,
  input logic [routerPkg::numPorts:0]   grantState,
  input logic [routerPkg::numPorts-1:0] pop,
  input logic                           sendValid,
  input logic                           sendReady,
  input routerPkg::flitWord             sendFlit
);
  timeunit 1ns;
  timeprecision 100ps;

  // idle is a state of its own, so exactly one bit is always set
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grantState))
    else $error("arbiter grant state is not one-hot");

  popNeedsReady: assert property (@(posedge clk) disable iff (rst) (|pop) |-> sendReady)
    else $error("a flit was popped while the link sender was not ready");

  sendHolds: assert property (@(posedge clk) disable iff (rst)
    (sendValid && !sendReady) |=> (sendValid && $stable(sendFlit)))
    else $error("sendValid or sendFlit changed before the transfer");

endmodule

bind switchArbiter arbiterProtocolChecks arbiterChecks
(
  .clk(clk),
  .rst(rst),
  .grantState(grantState),
  .pop(pop),
  .sendValid(sendValid),
  .sendReady(sendReady),
  .sendFlit(sendFlit)
);

`default_nettype wire

/* logic/routerOutputPort.sv */
`default_nettype none

module routerOutputPort
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic [routerPkg::numPorts-1:0] inValid,
  input  routerPkg::flitWord             inFlit [routerPkg::numPorts],
  output logic [routerPkg::numPorts-1:0] inReady,
  output logic                           outValid,
  output routerPkg::flitWord             outFlit,
  input  logic                           outReady
);

  logic [routerPkg::numPorts-1:0] headValid;
  routerPkg::flitWord headFlit [routerPkg::numPorts];
  logic [routerPkg::numPorts-1:0] pop;
  logic sendValid;
  routerPkg::flitWord sendFlit;
  logic sendReady;

  // one input FIFO per port, index order L, N, E, W, S
  for (genvar i = 0; i < routerPkg::numPorts; i++)
  begin : fifoGen
    flitFifo portFifo
    (
      .clk(clk),
      .rst(rst),
      .inValid(inValid[i]),
      .inFlit(inFlit[i]),
      .inReady(inReady[i]),
      .headValid(headValid[i]),
      .headFlit(headFlit[i]),
      .pop(pop[i])
    );
  end

  switchArbiter arbiter
  (
    .clk(clk),
    .rst(rst),
    .headValid(headValid),
    .headFlit(headFlit),
    .pop(pop),
    .sendValid(sendValid),
    .sendFlit(sendFlit),
    .sendReady(sendReady)
  );

  linkSender sender
  (
    .clk(clk),
    .rst(rst),
    .sendValid(sendValid),
    .sendFlit(sendFlit),
    .sendReady(sendReady),
    .outValid(outValid),
    .outFlit(outFlit),
    .outReady(outReady)
  );

endmodule

`default_nettype wire

/* logic/linkSender.sv */
`default_nettype none

module linkSender
(
  input  logic               clk,
  input  logic               rst,
  input  logic               sendValid,
  input  routerPkg::flitWord sendFlit,
  output logic               sendReady,
  output logic               outValid,
  output routerPkg::flitWord outFlit,
  input  logic               outReady
);

  routerPkg::flitWord buffer [2];
  logic wrSel;
  logic rdSel;
  logic [1:0] count;
  logic [1:0] countNext;
  logic push;
  logic take;

  assign push = sendValid && sendReady;
  assign take = outValid && outReady;
  assign outValid = (count != 2'd0);
  assign outFlit = buffer[rdSel];

  always_comb
  begin
    countNext = count;
    if (push && !take)
      countNext = count + 1'b1;
    else if (take && !push)
      countNext = count - 1'b1;
  end

  // ready looks one cycle ahead so it never depends on outReady directly
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= 2'd0;
      wrSel <= 1'b0;
      rdSel <= 1'b0;
      sendReady <= 1'b1;
    end
    else
    begin
      count <= countNext;
      sendReady <= (countNext != 2'd2);
      if (push)
        wrSel <= ~wrSel;
      if (take)
        rdSel <= ~rdSel;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      buffer[wrSel] <= sendFlit;
  end

endmodule

`default_nettype wire

/* logic/switchArbiter.sv */
`default_nettype none

module switchArbiter
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic [routerPkg::numPorts-1:0] headValid,
  input  routerPkg::flitWord             headFlit [routerPkg::numPorts],
  output logic [routerPkg::numPorts-1:0] pop,
  output logic                           sendValid,
  output routerPkg::flitWord             sendFlit,
  input  logic                           sendReady
);

  // one-hot state where bit 0 is idle and bit i+1 grants port i in the order L, N, E, W, S
  logic [routerPkg::numPorts:0] grantState;
  logic [routerPkg::numPorts-1:0] grant;
  logic [routerPkg::numPorts-1:0] lastFlit;
  logic [routerPkg::numPorts-1:0] pick;
  logic [routerPkg::portIdxWidth-1:0] startIdx;
  logic [routerPkg::portIdxWidth-1:0] grantIdx;
  logic [routerPkg::portIdxWidth-1:0] nextStart;
  logic packetDone;

  assign grant = grantState[routerPkg::numPorts:1];
  assign pop = grant & headValid & {routerPkg::numPorts{sendReady}};
  assign sendValid = |(grant & headValid);
  assign packetDone = |(pop & lastFlit);
  assign nextStart = (grantIdx == routerPkg::lastPortIdx) ? '0 : grantIdx + 1'b1;

  for (genvar i = 0; i < routerPkg::numPorts; i++)
  begin : timerGen
    packetTimer portTimer
    (
      .clk(clk),
      .rst(rst),
      .headFlit(headFlit[i]),
      .running(pop[i]),
      .lastFlit(lastFlit[i])
    );
  end

  always_comb
  begin
    sendFlit = '0;
    grantIdx = '0;
    for (int i = 0; i < routerPkg::numPorts; i++)
    begin
      if (grant[i])
      begin
        sendFlit = headFlit[i];
        grantIdx = routerPkg::portIdxWidth'(i);
      end
    end
  end

  // cyclic scan for the first waiting port at or after startIdx
  always_comb
  begin
    int idx;
    logic found;
    pick = '0;
    found = 1'b0;
    for (int k = 0; k < routerPkg::numPorts; k++)
    begin
      idx = int'(startIdx) + k;
      if (idx >= routerPkg::numPorts)
        idx = idx - routerPkg::numPorts;
      if (!found && headValid[idx])
      begin
        pick[idx] = 1'b1;
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grantState <= routerPkg::grantIdle;
      startIdx <= '0;
    end
    else if (grantState[0])
    begin
      if (pick != '0)
        grantState <= {pick, 1'b0};
      else
        // nothing waiting, so the next scan from idle begins at L again
        startIdx <= '0;
    end
    else if (packetDone)
    begin
      grantState <= routerPkg::grantIdle;
      startIdx <= nextStart;
    end
  end

endmodule

`default_nettype wire

/* logic/packetTimer.sv */
`default_nettype none

module packetTimer
(
  input  logic               clk,
  input  logic               rst,
  input  routerPkg::flitWord headFlit,
  input  logic               running,
  output logic               lastFlit
);

  logic [routerPkg::lengthWidth-1:0] count;
  logic [routerPkg::lengthWidth-1:0] lengthReg;
  logic [routerPkg::lengthWidth-1:0] packetLength;
  logic atHeader;

  // a header at the head with nothing counted yet opens a new packet
  assign atHeader = (count == '0) && (headFlit.header.flitId == routerPkg::flitIdHeader);
  assign packetLength = atHeader ? headFlit.header.length : lengthReg;

  // a length of zero behaves like a header-only packet
  assign lastFlit = running && ((count + 1'b1) >= packetLength);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      lengthReg <= '0;
    end
    else
    begin
      if (atHeader)
        lengthReg <= headFlit.header.length;
      if (lastFlit)
        count <= '0;
      else if (running)
        count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/flitFifo.sv */
`default_nettype none

module flitFifo
(
  input  logic               clk,
  input  logic               rst,
  input  logic               inValid,
  input  routerPkg::flitWord inFlit,
  output logic               inReady,
  output logic               headValid,
  output routerPkg::flitWord headFlit,
  input  logic               pop
);

  routerPkg::flitWord mem [routerPkg::fifoDepth];
  logic [routerPkg::fifoPtrWidth-1:0] wrPtr;
  logic [routerPkg::fifoPtrWidth-1:0] rdPtr;
  logic [routerPkg::fifoPtrWidth:0] count;
  logic push;
  logic take;

  assign headValid = (count != '0);
  assign headFlit = mem[rdPtr];
  assign take = pop && headValid;
  // a full FIFO still takes a flit in the cycle its head leaves
  assign inReady = (count != routerPkg::fifoFullCount) || take;
  assign push = inValid && inReady;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == routerPkg::fifoLastIdx) ? '0 : wrPtr + 1'b1;
      if (take)
        rdPtr <= (rdPtr == routerPkg::fifoLastIdx) ? '0 : rdPtr + 1'b1;
      if (push && !take)
        count <= count + 1'b1;
      else if (take && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

endmodule

`default_nettype wire

/* logic/routerPkg.sv */
`default_nettype none

package routerPkg;

  localparam int numPorts = 5;
  localparam int fifoDepth = 8;
  localparam int flitWidth = 32;
  localparam int idWidth = 3;
  localparam int lengthWidth = 12;
  localparam int portIdxWidth = $clog2(numPorts);
  localparam int fifoPtrWidth = $clog2(fifoDepth);

  localparam logic [idWidth-1:0] flitIdHeader = 3'd1;
  localparam logic [idWidth-1:0] flitIdBody = 3'd2;

  localparam logic [fifoPtrWidth-1:0] fifoLastIdx = fifoPtrWidth'(fifoDepth - 1);
  localparam logic [fifoPtrWidth:0] fifoFullCount = (fifoPtrWidth + 1)'(fifoDepth);
  localparam logic [portIdxWidth-1:0] lastPortIdx = portIdxWidth'(numPorts - 1);
  // bit 0 of the arbiter state means no port holds the output
  localparam logic [numPorts:0] grantIdle = (numPorts + 1)'(1);

  // length counts every flit of the packet, the header included
  typedef struct packed {
    logic [idWidth-1:0] flitId;
    logic [lengthWidth-1:0] length;
    logic [flitWidth-idWidth-lengthWidth-1:0] srcInfo;
  } headerFlit;

  typedef struct packed {
    logic [idWidth-1:0] flitId;
    logic [flitWidth-idWidth-1:0] payload;
  } bodyFlit;

  typedef union packed {
    headerFlit header;
    bodyFlit body;
  } flitWord;

endpackage

`default_nettype wire
